/* Bender.yml */
package:
  name: retire_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rob_types_pkg.sv
      - verilog/retire_types_pkg.sv
      - verilog/reorder_buffer.sv
      - verilog/retire_stage.sv
      - verilog/retire_config.sv
      - verilog/arch_register_file.sv
      - verilog/retire_unit_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/retire_unit_tb.sv

/* retire_unit_top.f */
+incdir+verilog
verilog/rob_types_pkg.sv
verilog/retire_types_pkg.sv
verilog/reorder_buffer.sv
verilog/retire_stage.sv
verilog/retire_config.sv
verilog/arch_register_file.sv
verilog/retire_unit_top.sv
verif/retire_unit_tb.sv

/* verif/retire_unit_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "retire_defines.svh"

module retire_unit_tb
  import rob_types_pkg::*;
  import retire_types_pkg::*;
();

  localparam int NUM_TESTS   = 6;
  localparam int EST_CYCLES  = 8 + NUM_TESTS * 34 + 135 * 3; // reset, sweeps, commits
  localparam int CYCLE_LIMIT = (EST_CYCLES * 6 + 999) / 1000 * 1000; // six times, rounded up

  logic                   clock;
  logic                   reset;
  logic                   dispatch_valid;
  dispatch_t              dispatch;
  logic                   dispatch_ready;
  logic [`ROB_TAG_W-1:0]  dispatch_tag;
  complete_t              complete1;
  complete_t              complete2;
  config_op_t             config_op;
  logic [`REG_ADDR_W-1:0] read_addr;
  logic [`DATA_W-1:0]     read_data;
  logic [`COUNT_W-1:0]    retire_count;

  logic [`DATA_W-1:0]    model_regs [`NUM_REGS]; // committed state, program order
  logic [`COUNT_W-1:0]   expected_count;
  logic [`COUNT_W-1:0]   last_count;
  logic [`ROB_TAG_W-1:0] model_tail; // next tag the ROB should hand out
  logic [63:0]           rng_state;
  logic [`ROB_TAG_W-1:0] batch_tag [2*`ROB_DEPTH];
  logic [`DATA_W-1:0]    batch_value [2*`ROB_DEPTH];
  int                    order [`ROB_DEPTH]; // completion order within a batch
  int                    cycle_count = 0;
  int                    check_count;
  int                    error_count;
  int                    test_start;
  logic                  single_watch;

  retire_unit_top u_dut (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .dispatch_ready (dispatch_ready),
    .dispatch_tag   (dispatch_tag),
    .complete1      (complete1),
    .complete2      (complete2),
    .config_op      (config_op),
    .read_addr      (read_addr),
    .read_data      (read_data),
    .retire_count   (retire_count)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, retire_count stuck at %0d of %0d",
               cycle_count, retire_count, expected_count);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // single mode, one retirement per cycle at most
  always @(negedge clock) begin
    if (single_watch) begin
      check_count++;
      assert (16'(retire_count - last_count) <= 16'd1) else begin
        $display("FAILED at %0t: retire_count rose from %0d to %0d in one cycle",
                 $time, last_count, retire_count);
        error_count++;
      end
    end
    last_count = retire_count;
  end

  function automatic logic [63:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
  endfunction

  // in-order commit, youngest write to a register wins
  function automatic void commit_model(input logic [4:0] dest_reg, input logic writes,
                                       input logic [63:0] value);
    if (writes && dest_reg != 5'd0) model_regs[dest_reg] = value;
    expected_count = expected_count + 1'b1; // x0 writes still retire
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    check_count++;
    assert (got === expected) else begin
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
      error_count++;
    end
  endtask

  task automatic issue(input int slot, input logic [4:0] dest_reg, input logic writes,
                       input logic [63:0] value);
    commit_model(dest_reg, writes, value);
    batch_value[slot] = value;
    dispatch_valid = 1'b1;
    dispatch = '{dest: dest_reg, has_dest: writes};
    while (!dispatch_ready) @(negedge clock); // held while the ROB is full
    check_value("dispatch_tag", dispatch_tag, model_tail); // tail index at acceptance
    batch_tag[slot] = dispatch_tag;
    model_tail = model_tail + 1'b1;
    @(negedge clock);
    dispatch_valid = 1'b0;
  endtask

  task automatic complete_pair(input int a, input int b);
    complete1 = '{valid: 1'b1, tag: batch_tag[a], value: batch_value[a]};
    if (b >= 0) complete2 = '{valid: 1'b1, tag: batch_tag[b], value: batch_value[b]};
    @(negedge clock);
    complete1 = '0;
    complete2 = '0;
  endtask

  task automatic run_batch(input int n, input bit random_order);
    int j;
    int tmp;
    int k;
    for (int i = 0; i < n; i++) begin
      issue(i, 5'(next_random()), next_random() % 8 != 0, next_random());
      order[i] = random_order ? i : n - 1 - i;
    end
    if (random_order) begin
      for (int i = n - 1; i > 0; i--) begin
        j = int'(next_random() % (i + 1));
        tmp = order[i];
        order[i] = order[j];
        order[j] = tmp;
      end
    end
    k = 0;
    while (k < n) begin
      if (random_order && k + 1 < n && next_random() % 2 == 1) begin
        complete_pair(order[k], order[k + 1]); // two units finish together
        k += 2;
      end else begin
        complete_pair(order[k], -1);
        k += 1;
      end
    end
  endtask

  task automatic compare_registers();
    while (retire_count != expected_count) @(negedge clock);
    for (int r = 0; r < `NUM_REGS; r++) begin
      read_addr = 5'(r);
      #2;
      check_value($sformatf("read_data x%0d", r), read_data, model_regs[r]);
      @(negedge clock);
    end
    check_value("retire_count", retire_count, expected_count);
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, error_count - test_start);
  endtask

  initial begin
    rng_state = 64'd97;
    reset = 1'b1;
    dispatch_valid = 1'b0;
    dispatch = '0;
    complete1 = '0;
    complete2 = '0;
    config_op = NOP;
    read_addr = '0;
    expected_count = '0;
    last_count = '0;
    model_tail = '0;
    check_count = 0;
    error_count = 0;
    single_watch = 1'b0;
    for (int r = 0; r < `NUM_REGS; r++) model_regs[r] = '0;
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    test_start = error_count;
    check_value("dispatch_ready", dispatch_ready, 1);
    compare_registers();
    end_test(1, "reset state");

    test_start = error_count;
    run_batch(8, 1'b0); // youngest completes first
    compare_registers();
    end_test(2, "reverse completion");

    test_start = error_count;
    for (int i = 0; i < 8; i++) issue(i, 5'(next_random()), 1'b1, next_random());
    check_value("dispatch_ready", dispatch_ready, 0);
    fork
      issue(8, 5'(next_random()), 1'b1, next_random());
      complete_pair(0, 1);
    join
    for (int i = 8; i >= 2; i--) complete_pair(i, -1);
    compare_registers();
    end_test(3, "back-pressure");

    test_start = error_count;
    issue(0, 5'd0, 1'b1, 64'hdead_beef_0000_0001);
    issue(1, 5'd3, 1'b1, next_random());
    complete_pair(0, 1);
    compare_registers();
    end_test(4, "x0 write");

    test_start = error_count;
    config_op = SET_SINGLE;
    @(negedge clock);
    config_op = NOP;
    single_watch = 1'b1;
    run_batch(8, 1'b1);
    run_batch(8, 1'b1);
    compare_registers();
    single_watch = 1'b0;
    config_op = CLEAR_COUNT;
    @(negedge clock);
    config_op = NOP;
    expected_count = '0;
    check_value("retire_count", retire_count, 0);
    end_test(5, "single mode");

    test_start = error_count;
    config_op = SET_DUAL;
    @(negedge clock);
    config_op = NOP;
    for (int b = 0; b < 12; b++) run_batch(8, 1'b1);
    run_batch(4, 1'b1); // 100 in total
    compare_registers();
    end_test(6, "random dual run");

    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/arch_register_file.sv */
`timescale 1ns/10ps
`default_nettype none

`include "retire_defines.svh"

module arch_register_file
  import retire_types_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  retire_slot_t           slot1,
  input  retire_slot_t           slot2,
  input  logic [`REG_ADDR_W-1:0] read_addr,
  output logic [`DATA_W-1:0]     read_data
);

  logic [`DATA_W-1:0] regs [`NUM_REGS];
  logic               write1;
  logic               write2;

  // x0 is hardwired, so writes to it are dropped
  assign write1 = slot1.valid && slot1.has_dest && (slot1.dest != '0);
  assign write2 = slot2.valid && slot2.has_dest && (slot2.dest != '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (write1) begin
        regs[slot1.dest] <= slot1.value;
      end
      // slot2 is younger, its write lands last on a collision
      if (write2) begin
        regs[slot2.dest] <= slot2.value;
      end
    end
  end

  assign read_data = regs[read_addr]; // async read port

endmodule

`default_nettype wire

/* verilog/reorder_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "retire_defines.svh"

module reorder_buffer
  import rob_types_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch_valid,
  input  dispatch_t             dispatch,
  output logic                  dispatch_ready,
  output logic [`ROB_TAG_W-1:0] dispatch_tag,
  input  complete_t             complete1,
  input  complete_t             complete2,
  input  logic [1:0]            pop_count,
  output rob_entry_t            head1,
  output rob_entry_t            head2
);

  // per-entry control bits
  logic [`ROB_DEPTH-1:0] busy_q;
  logic [`ROB_DEPTH-1:0] done_q;

  // per-entry payload
  logic [`REG_ADDR_W-1:0] dest_q     [`ROB_DEPTH];
  logic                   has_dest_q [`ROB_DEPTH];
  logic [`DATA_W-1:0]     value_q    [`ROB_DEPTH];

  logic [`ROB_TAG_W-1:0] head_ptr;
  logic [`ROB_TAG_W-1:0] head2_ptr;
  logic [`ROB_TAG_W-1:0] tail_ptr;
  logic [`ROB_TAG_W-1:0] pop_step;
  logic [`ROB_TAG_W:0]   occupancy; // one extra bit to tell full from empty
  logic [`ROB_TAG_W:0]   occupancy_next;
  logic                  dispatch_fire;
  logic                  complete1_hit;
  logic                  complete2_hit;

  assign dispatch_ready = (occupancy != `ROB_DEPTH);
  assign dispatch_fire  = dispatch_valid && dispatch_ready;
  assign dispatch_tag   = tail_ptr;

  // late completions to freed slots are dropped
  assign complete1_hit = complete1.valid && busy_q[complete1.tag];
  assign complete2_hit = complete2.valid && busy_q[complete2.tag];

  assign pop_step  = {{(`ROB_TAG_W-2){1'b0}}, pop_count};
  assign head2_ptr = head_ptr + 1'b1; // wraps, depth is a power of two

  assign occupancy_next = occupancy
                        + {{`ROB_TAG_W{1'b0}}, dispatch_fire}
                        - {{(`ROB_TAG_W-1){1'b0}}, pop_count};

  always_ff @(posedge clock) begin
    if (reset) begin
      head_ptr  <= '0;
      tail_ptr  <= '0;
      occupancy <= '0;
    end else begin
      head_ptr  <= head_ptr + pop_step;
      tail_ptr  <= tail_ptr + {{(`ROB_TAG_W-1){1'b0}}, dispatch_fire};
      occupancy <= occupancy_next;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q <= '0;
      done_q <= '0;
    end else begin
      // free retired slots first
      if (pop_count != 2'd0) begin
        busy_q[head_ptr] <= 1'b0;
        done_q[head_ptr] <= 1'b0;
      end
      if (pop_count == 2'd2) begin
        busy_q[head2_ptr] <= 1'b0;
        done_q[head2_ptr] <= 1'b0;
      end
      if (complete1_hit) begin
        done_q[complete1.tag] <= 1'b1;
      end
      if (complete2_hit) begin
        done_q[complete2.tag] <= 1'b1;
      end
      // tail slot is never the head unless empty, so no clash with a pop
      if (dispatch_fire) begin
        busy_q[tail_ptr] <= 1'b1;
        done_q[tail_ptr] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (complete1_hit) begin
      value_q[complete1.tag] <= complete1.value;
    end
    if (complete2_hit) begin
      value_q[complete2.tag] <= complete2.value;
    end
    if (dispatch_fire) begin
      dest_q[tail_ptr]     <= dispatch.dest;
      has_dest_q[tail_ptr] <= dispatch.has_dest;
    end
  end

  // two oldest entries for the retire stage
  always_comb begin
    head1.busy     = busy_q[head_ptr];
    head1.done     = done_q[head_ptr];
    head1.dest     = dest_q[head_ptr];
    head1.has_dest = has_dest_q[head_ptr];
    head1.value    = value_q[head_ptr];

    head2.busy     = busy_q[head2_ptr] && (occupancy > 1); // hidden with one entry
    head2.done     = done_q[head2_ptr];
    head2.dest     = dest_q[head2_ptr];
    head2.has_dest = has_dest_q[head2_ptr];
    head2.value    = value_q[head2_ptr];
  end

endmodule

`default_nettype wire

/* verilog/retire_config.sv */
`timescale 1ns/10ps
`default_nettype none

`include "retire_defines.svh"

module retire_config
  import retire_types_pkg::*;
(
  input  logic                clock,
  input  logic                reset,
  input  config_op_t          config_op,
  input  logic                slot1_valid,
  input  logic                slot2_valid,
  output logic                dual_enable,
  output logic [`COUNT_W-1:0] retire_count
);

  logic [`COUNT_W-1:0] retired_now; // 0, 1 or 2 this cycle

  assign retired_now = {{(`COUNT_W-1){1'b0}}, slot1_valid}
                     + {{(`COUNT_W-1){1'b0}}, slot2_valid};

  always_ff @(posedge clock) begin
    if (reset) begin
      dual_enable  <= 1'b1; // dual retire by default
      retire_count <= '0;
    end else begin
      case (config_op)
        SET_DUAL: begin
          dual_enable  <= 1'b1;
          retire_count <= retire_count + retired_now;
        end
        SET_SINGLE: begin
          dual_enable  <= 1'b0;
          retire_count <= retire_count + retired_now;
        end
        CLEAR_COUNT: begin
          retire_count <= '0;
        end
        default: begin
          retire_count <= retire_count + retired_now; // wraps
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/retire_defines.svh */
`ifndef RETIRE_DEFINES_SVH
`define RETIRE_DEFINES_SVH

// reorder buffer geometry
`define ROB_DEPTH 8 // in-flight entries
`define ROB_TAG_W 3 // log2 of ROB_DEPTH

// datapath
`define DATA_W 64 // result value width

// architectural registers
`define REG_ADDR_W 5 // register index width
`define NUM_REGS 32 // committed registers, x0 included

// retire statistics
`define COUNT_W 16 // wraps at this width

`endif

/* verilog/retire_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "retire_defines.svh"

module retire_stage
  import rob_types_pkg::*;
  import retire_types_pkg::*;
(
  input  logic          clock,
  input  logic          reset,
  input  rob_entry_t    head1,
  input  rob_entry_t    head2,
  input  logic          dual_enable,
  output logic [1:0]    pop_count,
  output retire_slot_t  slot1,
  output retire_slot_t  slot2,
  output retire_state_t state
);

  retire_state_t next_state;
  logic          head1_ok;
  logic          head2_ok;

  // captured head entries, qualified later by state
  logic [`REG_ADDR_W-1:0] dest1_q;
  logic [`REG_ADDR_W-1:0] dest2_q;
  logic                   has_dest1_q;
  logic                   has_dest2_q;
  logic [`DATA_W-1:0]     value1_q;
  logic [`DATA_W-1:0]     value2_q;

  assign head1_ok = head1.busy && head1.done;
  assign head2_ok = head1_ok && head2.busy && head2.done && dual_enable; // in order only

  always_comb begin
    if (head2_ok) begin
      next_state = BOTH_RETIRE;
      pop_count  = 2'd2;
    end else if (head1_ok) begin
      next_state = HEAD1_ONLY;
      pop_count  = 2'd1;
    end else begin
      next_state = NONE_RETIRE;
      pop_count  = 2'd0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge clock) begin
    dest1_q     <= head1.dest;
    has_dest1_q <= head1.has_dest;
    value1_q    <= head1.value;
    dest2_q     <= head2.dest;
    has_dest2_q <= head2.has_dest;
    value2_q    <= head2.value;
  end

  // slots follow the registered decision, idle and none send nothing
  always_comb begin
    slot1 = '0;
    slot2 = '0;
    case (state)
      BOTH_RETIRE: begin
        slot1 = '{valid: 1'b1, dest: dest1_q, has_dest: has_dest1_q, value: value1_q};
        slot2 = '{valid: 1'b1, dest: dest2_q, has_dest: has_dest2_q, value: value2_q};
      end
      HEAD1_ONLY: begin
        slot1 = '{valid: 1'b1, dest: dest1_q, has_dest: has_dest1_q, value: value1_q};
      end
      default: begin
        slot1 = '0;
        slot2 = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* verilog/retire_types_pkg.sv */
`default_nettype none

`include "retire_defines.svh"

package retire_types_pkg;

  // registered retire decision, encoded as in the older retire block
  typedef enum logic [1:0] {
    IDLE        = 2'b00, // out of reset
    BOTH_RETIRE = 2'b01, // head1 and head2 retired
    HEAD1_ONLY  = 2'b10, // head1 retired alone
    NONE_RETIRE = 2'b11  // nothing ready
  } retire_state_t;

  // one retiring instruction on its way to the register file
  typedef struct packed {
    logic                   valid;
    logic [`REG_ADDR_W-1:0] dest;
    logic                   has_dest;
    logic [`DATA_W-1:0]     value;
  } retire_slot_t;

  // requests to the configuration block
  typedef enum logic [1:0] {
    NOP         = 2'b00,
    SET_DUAL    = 2'b01, // allow two retirements per cycle
    SET_SINGLE  = 2'b10, // at most one per cycle
    CLEAR_COUNT = 2'b11  // zero the retired counter
  } config_op_t;

endpackage

`default_nettype wire

/* verilog/retire_unit_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "retire_defines.svh"

module retire_unit_top
  import rob_types_pkg::*;
  import retire_types_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   dispatch_valid,
  input  dispatch_t              dispatch,
  output logic                   dispatch_ready,
  output logic [`ROB_TAG_W-1:0]  dispatch_tag,
  input  complete_t              complete1,
  input  complete_t              complete2,
  input  config_op_t             config_op,
  input  logic [`REG_ADDR_W-1:0] read_addr,
  output logic [`DATA_W-1:0]     read_data,
  output logic [`COUNT_W-1:0]    retire_count
);

  rob_entry_t    head1;
  rob_entry_t    head2;
  logic [1:0]    pop_count;
  retire_slot_t  slot1;
  retire_slot_t  slot2;
  logic          dual_enable;

  reorder_buffer u_rob (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .dispatch_ready (dispatch_ready),
    .dispatch_tag   (dispatch_tag),
    .complete1      (complete1),
    .complete2      (complete2),
    .pop_count      (pop_count),
    .head1          (head1),
    .head2          (head2)
  );

  retire_stage u_retire (
    .clock       (clock),
    .reset       (reset),
    .head1       (head1),
    .head2       (head2),
    .dual_enable (dual_enable),
    .pop_count   (pop_count),
    .slot1       (slot1),
    .slot2       (slot2),
    .state       ()
  );

  retire_config u_config (
    .clock        (clock),
    .reset        (reset),
    .config_op    (config_op),
    .slot1_valid  (slot1.valid),
    .slot2_valid  (slot2.valid),
    .dual_enable  (dual_enable),
    .retire_count (retire_count)
  );

  arch_register_file u_regfile (
    .clock     (clock),
    .reset     (reset),
    .slot1     (slot1),
    .slot2     (slot2),
    .read_addr (read_addr),
    .read_data (read_data)
  );

endmodule

`default_nettype wire

/* verilog/rob_types_pkg.sv */
`default_nettype none

`include "retire_defines.svh"

package rob_types_pkg;

  // what the front end hands the ROB on dispatch
  typedef struct packed {
    logic [`REG_ADDR_W-1:0] dest;     // destination register
    logic                   has_dest; // instruction writes a register
  } dispatch_t;

  // one completion strobe from an execution unit
  typedef struct packed {
    logic                  valid;
    logic [`ROB_TAG_W-1:0] tag;   // entry being completed
    logic [`DATA_W-1:0]    value; // result
  } complete_t;

  // one ROB slot as seen by the retire stage
  typedef struct packed {
    logic                   busy;     // slot holds an instruction
    logic                   done;     // result has arrived
    logic [`REG_ADDR_W-1:0] dest;
    logic                   has_dest;
    logic [`DATA_W-1:0]     value;
  } rob_entry_t;

endpackage

`default_nettype wire
